// ==== verilog.f ====
+incdir+tests
src/periph_pkg.sv
src/dbus_ctrl.sv
src/mtimer.sv
src/uart_tx.sv
src/irq_reg.sv
src/periph_top.sv
tests/tb_periph.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_periph -f verilog.f -o sim_periph \
    && ./obj_dir/sim_periph > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== tests/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

    // Galois form shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    // One LFSR step for every bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s (%s): expected %h, actual %h",
                     test_name, name, exp, act);
            err_cnt++;
        end
    endtask

    // Starts on a falling edge and returns on the falling edge where ack is seen
    task automatic run_request(input logic wr, input logic [31:0] a, input logic [31:0] d,
                               output logic [31:0] r);
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        cyc = 1'b1;
        we  = wr;
        adr = a;
        dat = d;
        while (!got && n < BUS_TIMEOUT) begin
            @(negedge ck);
            n++;
            got = ack;
        end
        r   = rdt;
        cyc = 1'b0;
        we  = 1'b0;
        if (!got) begin
            $display("ERROR: no bus acknowledge for address %h after %0d cycles", a, n);
            err_cnt++;
        end
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        logic [31:0] r;
        run_request(1'b1, a, d, r);
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] r);
        run_request(1'b0, a, 32'd0, r);
    endtask

    // Reads a register until one bit reaches the wanted level
    task automatic poll_bit(input logic [31:0] a, input int bit_pos, input logic want,
                            input string what);
        logic [31:0] v;
        int          n;
        n = 0;
        bus_read(a, v);
        while (v[bit_pos] !== want && n < POLL_LIMIT) begin
            bus_read(a, v);
            n++;
        end
        if (v[bit_pos] !== want) begin
            $display("ERROR: %s did not happen within %0d reads", what, POLL_LIMIT);
            err_cnt++;
        end
    endtask

`endif

// ==== tests/tb_periph.sv ====
`timescale 1ns/100ps

module tb_periph;

    localparam int BAUD_DIV    = 16;
    localparam int BUS_TIMEOUT = 16;
    localparam int POLL_LIMIT  = 400;
    localparam int RX_LIMIT    = 40 * 10 * BAUD_DIV;
    localparam int W           = periph_pkg::IRQ_W;

    localparam logic [31:0] IRQ_MASK  = (32'd1 << W) - 32'd1;
    localparam logic [31:0] TMR_BASE  = {periph_pkg::TIMER_ADDR, 24'd0};
    localparam logic [31:0] UART_BASE = {periph_pkg::UART_ADDR, 24'd0};
    localparam logic [31:0] IRQ_BASE  = {periph_pkg::IRQ_ADDR, 24'd0};
    localparam logic [31:0] A_TIME_LO = TMR_BASE | (32'(periph_pkg::TMR_TIME_LO) << 2);
    localparam logic [31:0] A_TIME_HI = TMR_BASE | (32'(periph_pkg::TMR_TIME_HI) << 2);
    localparam logic [31:0] A_CMP_LO  = TMR_BASE | (32'(periph_pkg::TMR_CMP_LO) << 2);
    localparam logic [31:0] A_CMP_HI  = TMR_BASE | (32'(periph_pkg::TMR_CMP_HI) << 2);
    localparam logic [31:0] A_UART    = UART_BASE | (32'(periph_pkg::UART_DATA) << 2);
    localparam logic [31:0] A_PEND    = IRQ_BASE | (32'(periph_pkg::IRQ_PENDING) << 2);
    localparam logic [31:0] A_EN      = IRQ_BASE | (32'(periph_pkg::IRQ_ENABLE) << 2);

    logic        ck;
    logic        reset;
    logic        cyc;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic        ext_irq;
    logic        ack;
    logic [31:0] rdt;
    logic        tx;
    logic        irq;

    int          err_cnt;
    int          tests_run;
    int          tests_failed;
    int          test_err_base;
    string       test_name;
    logic [31:0] lfsr;

    // Serial monitor state
    logic        mon_active;
    int          mon_cnt;
    int          mon_slot;
    logic [7:0]  mon_shift;
    logic [7:0]  rx_bytes[$];
    logic [7:0]  exp_bytes[$];

    `include "tb_bus_tasks.svh"

    periph_top #(.BAUD_DIV(BAUD_DIV)) uut (
        .ck           (ck),
        .i_reset_loop (reset),
        .i_cyc        (cyc),
        .i_we         (we),
        .i_adr        (adr),
        .i_dat        (dat),
        .i_ext_irq    (ext_irq),
        .o_ack        (ack),
        .o_rdt        (rdt),
        .o_tx         (tx),
        .o_irq        (irq)
    );

    always #4 ck = ~ck;

    // Interrupt line expected from the modelled pending and enable bits
    function automatic logic irq_ref(input logic [W-1:0] pend, input logic [W-1:0] en);
        return |(pend & en);
    endfunction

    // Only the low byte of a written word goes out on the line
    function automatic logic [7:0] line_byte(input logic [31:0] word);
        return word[7:0];
    endfunction

    // Samples o_tx at mid-bit, counted from the falling edge that saw the start bit
    always @(negedge ck) begin
        if (reset) begin
            mon_active = 1'b0;
        end else if (!mon_active) begin
            if (tx === 1'b0) begin
                mon_active = 1'b1;
                mon_cnt    = 0;
            end
        end else begin
            mon_cnt++;
            if (mon_cnt % BAUD_DIV == BAUD_DIV / 2 - 1) begin
                mon_slot = mon_cnt / BAUD_DIV;
                if (mon_slot == 0 && tx !== 1'b0) begin
                    $display("ERROR: serial start bit did not hold low to mid-bit");
                    err_cnt++;
                    mon_active = 1'b0;
                end else if (mon_slot >= 1 && mon_slot <= 8) begin
                    mon_shift = {tx, mon_shift[7:1]};
                end else if (mon_slot == 9) begin
                    if (tx === 1'b1) begin
                        rx_bytes.push_back(mon_shift);
                    end else begin
                        $display("ERROR: serial stop bit missing after byte %h", mon_shift);
                        err_cnt++;
                    end
                    mon_active = 1'b0;
                end
            end
        end
    end

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == test_err_base) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", test_name, err_cnt - test_err_base);
        end
    endtask

    // o_irq is registered, so give it two edges to settle
    task automatic check_irq(input string name, input logic [W-1:0] pend,
                             input logic [W-1:0] en);
        repeat (2) @(negedge ck);
        check_val(name, 32'(irq_ref(pend, en)), 32'(irq));
    endtask

    task automatic wait_rx_count(input int count);
        int n;
        n = 0;
        while (rx_bytes.size() < count && n < RX_LIMIT) begin
            @(negedge ck);
            n++;
        end
        if (rx_bytes.size() < count) begin
            $display("ERROR: only %0d serial bytes seen, waited for %0d",
                     rx_bytes.size(), count);
            err_cnt++;
        end
    endtask

    task automatic compare_bytes();
        check_val("serial byte count", 32'(exp_bytes.size()), 32'(rx_bytes.size()));
        for (int i = 0; i < exp_bytes.size() && i < rx_bytes.size(); i++) begin
            check_val($sformatf("serial byte %0d", i), 32'(exp_bytes[i]), 32'(rx_bytes[i]));
        end
    endtask

    task automatic check_unmapped(input logic [7:0] top);
        logic [31:0] v;
        logic [31:0] a;
        take_bits(24, a);
        a = {top, a[23:0]};
        bus_write(a, 32'hffffffff);
        bus_read(a, v);
        check_val($sformatf("unmapped read at %h", a), 32'd0, v);
    endtask

    initial begin
        logic [31:0]  v;
        logic [31:0]  w;
        logic [W-1:0] pend;
        logic [W-1:0] en;

        ck           = 1'b0;
        reset        = 1'b1;
        cyc          = 1'b0;
        we           = 1'b0;
        adr          = 32'd0;
        dat          = 32'd0;
        ext_irq      = 1'b0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr         = 32'h791c615f;
        mon_active   = 1'b0;
        repeat (5) @(negedge ck);
        reset = 1'b0;

        begin_test("reset_state");
        check_val("tx idle level", 32'd1, 32'(tx));
        check_val("irq after reset", 32'd0, 32'(irq));
        bus_read(A_PEND, v);
        check_val("pending after reset", 32'd0, v);
        bus_read(A_EN, v);
        check_val("enable after reset", 32'd0, v);
        bus_read(A_CMP_LO, v);
        check_val("cmp_lo after reset", 32'hffffffff, v);
        bus_read(A_CMP_HI, v);
        check_val("cmp_hi after reset", 32'hffffffff, v);
        bus_read(A_UART, v);
        check_val("uart busy after reset", 32'd0, v);
        end_test();

        begin_test("readback");
        take_bits(32, v);
        bus_write(A_CMP_LO, v);
        bus_read(A_CMP_LO, w);
        check_val("cmp_lo readback", v, w);
        take_bits(32, v);
        bus_write(A_CMP_HI, v);
        bus_read(A_CMP_HI, w);
        check_val("cmp_hi readback", v, w);
        take_bits(32, v);
        bus_write(A_EN, v);
        bus_read(A_EN, w);
        check_val("enable readback", v & IRQ_MASK, w);
        check_unmapped(8'h00);
        check_unmapped(8'h51);
        check_unmapped(8'hff);
        end_test();

        begin_test("timer_irq");
        // Park compare high first, then drop anything left over
        bus_write(A_CMP_HI, 32'hffffffff);
        bus_write(A_CMP_LO, 32'hffffffff);
        bus_write(A_EN, 32'd0);
        bus_write(A_PEND, IRQ_MASK);
        bus_write(A_TIME_LO, 32'd0);
        bus_write(A_TIME_HI, 32'd0);
        bus_write(A_CMP_LO, 32'd200);
        bus_write(A_CMP_HI, 32'd0);
        bus_read(A_PEND, v);
        check_val("timer pending before compare", 32'd0, 32'(v[periph_pkg::IRQ_TIMER]));
        poll_bit(A_PEND, periph_pkg::IRQ_TIMER, 1'b1, "timer pending set");
        pend = W'(1 << periph_pkg::IRQ_TIMER);
        en   = W'(1 << periph_pkg::IRQ_TIMER);
        bus_write(A_EN, 32'(en));
        check_irq("irq with timer pending", pend, en);
        bus_write(A_PEND, 32'(pend));
        pend = '0;
        bus_read(A_PEND, v);
        check_val("timer pending after clear", 32'd0, v);
        check_irq("irq after timer clear", pend, en);
        bus_write(A_CMP_HI, 32'hffffffff);
        bus_write(A_CMP_LO, 32'hffffffff);
        bus_write(A_EN, 32'd0);
        end_test();

        begin_test("uart_tx");
        for (int i = 0; i < 8; i++) begin
            take_bits(32, v);
            poll_bit(A_UART, 0, 1'b0, "uart idle");
            bus_write(A_UART, v);
            exp_bytes.push_back(line_byte(v));
        end
        wait_rx_count(8);
        compare_bytes();
        // Second write lands while the first frame is still going
        take_bits(32, v);
        take_bits(32, w);
        poll_bit(A_UART, 0, 1'b0, "uart idle");
        bus_write(A_UART, v);
        exp_bytes.push_back(line_byte(v));
        bus_read(A_UART, v);
        check_val("busy after write", 32'd1, v);
        bus_write(A_UART, w);
        bus_read(A_UART, v);
        check_val("busy after write while busy", 32'd1, v);
        wait_rx_count(9);
        poll_bit(A_UART, 0, 1'b0, "uart idle");
        repeat (20 * BAUD_DIV) @(negedge ck);
        compare_bytes();
        end_test();

        begin_test("irq_sources");
        bus_write(A_EN, 32'd0);
        bus_write(A_PEND, IRQ_MASK);
        pend = '0;
        bus_read(A_PEND, v);
        check_val("pending after clear", 32'(pend), v);
        ext_irq = 1'b1;
        repeat (2) @(negedge ck);
        ext_irq = 1'b0;
        poll_bit(A_PEND, periph_pkg::IRQ_EXT, 1'b1, "external pending set");
        take_bits(32, v);
        poll_bit(A_UART, 0, 1'b0, "uart idle");
        bus_write(A_UART, v);
        exp_bytes.push_back(line_byte(v));
        poll_bit(A_PEND, periph_pkg::IRQ_UART, 1'b1, "uart pending set");
        pend = W'((1 << periph_pkg::IRQ_EXT) | (1 << periph_pkg::IRQ_UART));
        bus_read(A_PEND, v);
        check_val("pending ext and uart", 32'(pend), v);
        for (int m = 0; m < (1 << W); m++) begin
            en = W'(m);
            bus_write(A_EN, 32'(en));
            check_irq($sformatf("irq with mask %0d", m), pend, en);
        end
        bus_write(A_PEND, IRQ_MASK);
        pend = '0;
        for (int n = 0; irq !== 1'b0 && n < POLL_LIMIT; n++) begin
            @(negedge ck);
        end
        check_irq("irq after clearing all", pend, en);
        wait_rx_count(10);
        compare_bytes();
        end_test();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== src/periph_top.sv ====
`timescale 1ns/100ps

module periph_top #(
    parameter int BAUD_DIV = 104
) (
    input  logic        ck,
    input  logic        i_reset_loop,
    input  logic        i_cyc,
    input  logic        i_we,
    input  logic [31:0] i_adr,
    input  logic [31:0] i_dat,
    input  logic        i_ext_irq,
    output logic        o_ack,
    output logic [31:0] o_rdt,
    output logic        o_tx,
    output logic        o_irq
);

    // Controller to device request lines
    logic        timer_stb;
    logic        uart_stb;
    logic        irq_stb;
    logic        dev_we;
    logic [1:0]  dev_off;
    logic [31:0] dev_wdat;

    // Device read words
    logic [31:0] timer_rdt;
    logic [31:0] uart_rdt;
    logic [31:0] irq_rdt;

    // Interrupt sources
    logic        timer_irq;
    logic        tx_done;

    dbus_ctrl u_ctrl (
        .ck           (ck),
        .i_reset_loop (i_reset_loop),
        .i_cyc        (i_cyc),
        .i_we         (i_we),
        .i_adr        (i_adr),
        .i_dat        (i_dat),
        .i_timer_rdt  (timer_rdt),
        .i_uart_rdt   (uart_rdt),
        .i_irq_rdt    (irq_rdt),
        .o_ack        (o_ack),
        .o_rdt        (o_rdt),
        .o_timer_stb  (timer_stb),
        .o_uart_stb   (uart_stb),
        .o_irq_stb    (irq_stb),
        .o_we         (dev_we),
        .o_off        (dev_off),
        .o_wdat       (dev_wdat)
    );

    mtimer u_timer (
        .ck           (ck),
        .i_reset_loop (i_reset_loop),
        .i_stb        (timer_stb),
        .i_we         (dev_we),
        .i_off        (dev_off),
        .i_wdat       (dev_wdat),
        .o_rdt        (timer_rdt),
        .o_timer_irq  (timer_irq)
    );

    // Only the low byte carries UART data
    uart_tx #(.BAUD_DIV(BAUD_DIV)) u_uart (
        .ck           (ck),
        .i_reset_loop (i_reset_loop),
        .i_stb        (uart_stb),
        .i_we         (dev_we),
        .i_wdat       (dev_wdat[7:0]),
        .o_rdt        (uart_rdt),
        .o_tx         (o_tx),
        .o_tx_done    (tx_done)
    );

    irq_reg u_irq (
        .ck           (ck),
        .i_reset_loop (i_reset_loop),
        .i_stb        (irq_stb),
        .i_we         (dev_we),
        .i_off        (dev_off),
        .i_wdat       (dev_wdat),
        .i_timer_irq  (timer_irq),
        .i_tx_done    (tx_done),
        .i_ext_irq    (i_ext_irq),
        .o_rdt        (irq_rdt),
        .o_irq        (o_irq)
    );

endmodule

// ==== src/irq_reg.sv ====
`timescale 1ns/100ps

module irq_reg (
    input  logic        ck,
    input  logic        i_reset_loop,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [1:0]  i_off,
    input  logic [31:0] i_wdat,
    input  logic        i_timer_irq,
    input  logic        i_tx_done,
    input  logic        i_ext_irq,
    output logic [31:0] o_rdt,
    output logic        o_irq
);

    localparam int W = periph_pkg::IRQ_W;

    logic         ext_meta;
    logic         ext_sync;
    logic [W-1:0] src;
    logic [W-1:0] src_q;
    logic [W-1:0] rise;
    logic [W-1:0] clr;
    logic [W-1:0] pending;
    logic [W-1:0] enable;

    always_comb begin
        src                       = '0;
        src[periph_pkg::IRQ_TIMER] = i_timer_irq;
        src[periph_pkg::IRQ_UART]  = i_tx_done;
        src[periph_pkg::IRQ_EXT]   = ext_sync;
    end

    assign rise = src & ~src_q;
    // Write one to clear
    assign clr  = (i_stb && i_we && (i_off == periph_pkg::IRQ_PENDING)) ? i_wdat[W-1:0] : '0;

    always_ff @(posedge ck) begin
        if (i_reset_loop) begin
            ext_meta <= 1'b0;
            ext_sync <= 1'b0;
            src_q    <= '0;
            pending  <= '0;
            enable   <= '0;
            o_irq    <= 1'b0;
        end else begin
            // External pin is asynchronous
            ext_meta <= i_ext_irq;
            ext_sync <= ext_meta;
            src_q    <= src;
            // A new edge beats a clear in the same cycle
            pending  <= (pending & ~clr) | rise;
            if (i_stb && i_we && (i_off == periph_pkg::IRQ_ENABLE)) begin
                enable <= i_wdat[W-1:0];
            end
            o_irq <= |(pending & enable);
        end
    end

    always_comb begin
        case (i_off)
            periph_pkg::IRQ_PENDING: o_rdt = {{(32-W){1'b0}}, pending};
            periph_pkg::IRQ_ENABLE:  o_rdt = {{(32-W){1'b0}}, enable};
            default:                 o_rdt = 32'd0;
        endcase
    end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx #(
    parameter int BAUD_DIV = 104
) (
    input  logic        ck,
    input  logic        i_reset_loop,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [7:0]  i_wdat,
    output logic [31:0] o_rdt,
    output logic        o_tx,
    output logic        o_tx_done
);

    localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BAUD_DIV - 1);

    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       shreg;
    logic             busy;
    logic             bit_end;

    // Last cycle of the current bit
    assign bit_end = busy && (baud_cnt == BAUD_LAST);

    always_ff @(posedge ck) begin
        if (i_reset_loop) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= 4'd0;
            shreg    <= '1;
        end else if (!busy) begin
            if (i_stb && i_we) begin
                // Stop, data LSB first, start
                shreg    <= {1'b1, i_wdat, 1'b0};
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= 4'd0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
                shreg   <= {1'b1, shreg[9:1]};
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // Line idles high, shreg refills with ones
    assign o_tx = shreg[0];

    assign o_tx_done = bit_end && (bit_cnt == 4'd9);

    assign o_rdt = {31'd0, busy};

endmodule

// ==== src/mtimer.sv ====
`timescale 1ns/100ps

module mtimer (
    input  logic        ck,
    input  logic        i_reset_loop,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [1:0]  i_off,
    input  logic [31:0] i_wdat,
    output logic [31:0] o_rdt,
    output logic        o_timer_irq
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        wr;

    assign wr = i_stb && i_we;

    // Free running count, a write to either half wins over the increment
    always_ff @(posedge ck) begin
        if (i_reset_loop) begin
            mtime <= 64'd0;
        end else if (wr && (i_off == periph_pkg::TMR_TIME_LO)) begin
            mtime <= {mtime[63:32], i_wdat};
        end else if (wr && (i_off == periph_pkg::TMR_TIME_HI)) begin
            mtime <= {i_wdat, mtime[31:0]};
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // Compare starts at all ones so nothing fires out of reset
    always_ff @(posedge ck) begin
        if (i_reset_loop) begin
            mtimecmp <= '1;
        end else if (wr) begin
            case (i_off)
                periph_pkg::TMR_CMP_LO: mtimecmp[31:0]  <= i_wdat;
                periph_pkg::TMR_CMP_HI: mtimecmp[63:32] <= i_wdat;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (i_off)
            periph_pkg::TMR_TIME_LO: o_rdt = mtime[31:0];
            periph_pkg::TMR_TIME_HI: o_rdt = mtime[63:32];
            periph_pkg::TMR_CMP_LO:  o_rdt = mtimecmp[31:0];
            periph_pkg::TMR_CMP_HI:  o_rdt = mtimecmp[63:32];
            default:                 o_rdt = 32'd0;
        endcase
    end

    // Level stays high until compare is moved past time
    assign o_timer_irq = (mtime >= mtimecmp);

endmodule

// ==== src/dbus_ctrl.sv ====
`timescale 1ns/100ps

module dbus_ctrl (
    input  logic        ck,
    input  logic        i_reset_loop,
    input  logic        i_cyc,
    input  logic        i_we,
    input  logic [31:0] i_adr,
    input  logic [31:0] i_dat,
    input  logic [31:0] i_timer_rdt,
    input  logic [31:0] i_uart_rdt,
    input  logic [31:0] i_irq_rdt,
    output logic        o_ack,
    output logic [31:0] o_rdt,
    output logic        o_timer_stb,
    output logic        o_uart_stb,
    output logic        o_irq_stb,
    output logic        o_we,
    output logic [1:0]  o_off,
    output logic [31:0] o_wdat
);

    periph_pkg::bus_state_t state;
    periph_pkg::dev_t       sel;
    periph_pkg::dev_t       dev;
    logic                   start;
    logic [31:0]            rdt_mux;

    // Address decode on the top byte
    always_comb begin
        case (i_adr[31:24])
            periph_pkg::TIMER_ADDR: dev = periph_pkg::DEV_TIMER;
            periph_pkg::UART_ADDR:  dev = periph_pkg::DEV_UART;
            periph_pkg::IRQ_ADDR:   dev = periph_pkg::DEV_IRQ;
            default:                dev = periph_pkg::DEV_NONE;
        endcase
    end

    // A new request is only taken in idle
    assign start = (state == periph_pkg::BUS_IDLE) && i_cyc;

    // Read word of the device chosen at request time
    always_comb begin
        case (sel)
            periph_pkg::DEV_TIMER: rdt_mux = i_timer_rdt;
            periph_pkg::DEV_UART:  rdt_mux = i_uart_rdt;
            periph_pkg::DEV_IRQ:   rdt_mux = i_irq_rdt;
            default:               rdt_mux = 32'd0;
        endcase
    end

    always_ff @(posedge ck) begin
        if (i_reset_loop) begin
            state       <= periph_pkg::BUS_IDLE;
            sel         <= periph_pkg::DEV_NONE;
            o_timer_stb <= 1'b0;
            o_uart_stb  <= 1'b0;
            o_irq_stb   <= 1'b0;
            o_ack       <= 1'b0;
            o_rdt       <= 32'd0;
        end else begin
            o_timer_stb <= start && (dev == periph_pkg::DEV_TIMER);
            o_uart_stb  <= start && (dev == periph_pkg::DEV_UART);
            o_irq_stb   <= start && (dev == periph_pkg::DEV_IRQ);

            // Ack and data go out together, data is zero otherwise
            o_ack <= (state == periph_pkg::BUS_ACK);
            o_rdt <= (state == periph_pkg::BUS_ACK) ? rdt_mux : 32'd0;

            case (state)
                periph_pkg::BUS_IDLE: begin
                    if (i_cyc) begin
                        state <= periph_pkg::BUS_ACK;
                        sel   <= dev;
                    end
                end
                periph_pkg::BUS_ACK: begin
                    // i_cyc still high here belongs to the same request
                    state <= periph_pkg::BUS_IDLE;
                end
                default: state <= periph_pkg::BUS_IDLE;
            endcase
        end
    end

    // Request payload for the devices
    always_ff @(posedge ck) begin
        if (start) begin
            o_we   <= i_we;
            o_off  <= i_adr[3:2];
            o_wdat <= i_dat;
        end
    end

endmodule

// ==== src/periph_pkg.sv ====
package periph_pkg;

    // Device select, address bits 31 to 24
    localparam logic [7:0] TIMER_ADDR = 8'hc0;
    localparam logic [7:0] UART_ADDR  = 8'h50;
    localparam logic [7:0] IRQ_ADDR   = 8'h80;

    // Timer register offsets, address bits 3 to 2
    localparam logic [1:0] TMR_TIME_LO = 2'd0;
    localparam logic [1:0] TMR_TIME_HI = 2'd1;
    localparam logic [1:0] TMR_CMP_LO  = 2'd2;
    localparam logic [1:0] TMR_CMP_HI  = 2'd3;

    // UART data register; read gives busy in bit 0
    localparam logic [1:0] UART_DATA = 2'd0;

    // Interrupt register offsets
    localparam logic [1:0] IRQ_PENDING = 2'd0;
    localparam logic [1:0] IRQ_ENABLE  = 2'd1;

    // Interrupt sources and their bit positions
    localparam int IRQ_W     = 3;
    localparam int IRQ_TIMER = 0;
    localparam int IRQ_UART  = 1;
    localparam int IRQ_EXT   = 2;

    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_TIMER,
        DEV_UART,
        DEV_IRQ
    } dev_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_t;

endpackage
